//--- include/div_macros.svh
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// operand widths of the divide unit
`define DIV_DIVIDEND_WIDTH 16
`define DIV_DIVISOR_WIDTH 8

// radix-8 long division, one digit per cycle
`define DIV_DIGIT_BITS 3
// 6 digits cover 18 bits, dividend gets 2 zero bits on top
`define DIV_DIGITS 6

// wishbone word address and data widths
`define WB_ADR_WIDTH 4
`define WB_DATA_WIDTH 32

`endif

//--- logic/div_pkg.sv
`include "div_macros.svh"

package div_pkg;

	// packed so that the layout matches the operand register
	// dividend in the low bits, divisor above it
	typedef struct packed {
		logic [`DIV_DIVISOR_WIDTH-1:0]  divisor;
		logic [`DIV_DIVIDEND_WIDTH-1:0] dividend;
	} div_operands_t;

	typedef struct packed {
		logic                           div_by_zero;
		logic [`DIV_DIVISOR_WIDTH-1:0]  remainder;
		logic [`DIV_DIVIDEND_WIDTH-1:0] quotient;
	} div_result_t;

	// everything the bus master drives
	typedef struct packed {
		logic                     cyc;
		logic                     stb;
		logic                     we;
		logic [`WB_ADR_WIDTH-1:0] adr;
		logic [`WB_DATA_WIDTH-1:0] dat;
	} wb_req_t;

	// everything the slave drives back
	typedef struct packed {
		logic                      ack;
		logic [`WB_DATA_WIDTH-1:0] dat;
	} wb_rsp_t;

	typedef enum logic {
		DIV_IDLE,
		DIV_WORK
	} div_state_e;

	// word addresses of the register block
	// operands: write only, a write starts a division
	// status: read only, busy / done / div_by_zero in bits 0..2
	// result: read only, reading clears done
	typedef enum logic [`WB_ADR_WIDTH-1:0] {
		REG_OPERANDS = 4'd0,
		REG_STATUS   = 4'd1,
		REG_RESULT   = 4'd2
	} wb_reg_e;

endpackage

//--- logic/div_unit_top.sv
module div_unit_top
	import div_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  wb_req_t wb_in,
	output wb_rsp_t wb_out
);

	logic          start;
	div_operands_t operands;
	logic          ready;
	div_result_t   result;
	logic          result_valid;

	// bus side, status and result registers
	div_wb_regs u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.wb_in        (wb_in),
		.wb_out       (wb_out),
		.ready        (ready),
		.result       (result),
		.result_valid (result_valid),
		.start        (start),
		.operands     (operands)
	);

	// iterative divider, one division in flight
	radix8_long_div u_div (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.operands     (operands),
		.ready        (ready),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

//--- logic/div_wb_regs.sv
`include "div_macros.svh"

module div_wb_regs
	import div_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  wb_req_t       wb_in,
	output wb_rsp_t       wb_out,
	input  logic          ready,
	input  div_result_t   result,
	input  logic          result_valid,
	output logic          start,
	output div_operands_t operands
);

	localparam int DATA_W = `WB_DATA_WIDTH;
	localparam int OPS_W  = $bits(div_operands_t);

	logic              req;
	wb_reg_e           reg_sel;
	logic              op_write;
	// request seen and waiting for its ack edge
	logic              active_q;
	logic              finish;
	logic              launch;

	logic              ack_q;
	logic [DATA_W-1:0] rdata_q;
	logic              start_q;
	logic              busy_q;
	logic              done_q;
	div_result_t       result_q;
	div_operands_t     operands_q;

	assign req      = wb_in.cyc && wb_in.stb;
	assign reg_sel  = wb_reg_e'(wb_in.adr);
	assign op_write = wb_in.we && (reg_sel == REG_OPERANDS);

	// operand writes stall until the core is idle
	assign finish = active_q && req && (!op_write || ready);
	assign launch = finish && op_write;

	assign wb_out   = '{ack: ack_q, dat: rdata_q};
	assign start    = start_q;
	assign operands = operands_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active_q <= 1'b0;
			ack_q    <= 1'b0;
			rdata_q  <= '0;
			start_q  <= 1'b0;
			busy_q   <= 1'b0;
			done_q   <= 1'b0;
			result_q <= '0;
		end
		else
		begin
			ack_q   <= 1'b0;
			start_q <= 1'b0;

			// stb may linger for the cycle after ack
			if (req && !active_q && !ack_q)
			begin
				active_q <= 1'b1;
			end
			else if (active_q && !req)
			begin
				active_q <= 1'b0;
			end

			if (finish)
			begin
				active_q <= 1'b0;
				ack_q    <= 1'b1;
				rdata_q  <= '0;
				if (!wb_in.we)
				begin
					case (reg_sel)
						REG_STATUS:
						begin
							rdata_q <= DATA_W'({result_q.div_by_zero, done_q, busy_q});
						end
						REG_RESULT:
						begin
							rdata_q <= DATA_W'({result_q.remainder, result_q.quotient});
							done_q  <= 1'b0;
						end
						default:
						begin
							rdata_q <= '0;
						end
					endcase
				end
			end

			// capture wins over a read clear on the same edge
			if (result_valid)
			begin
				result_q <= result;
				busy_q   <= 1'b0;
				done_q   <= 1'b1;
			end

			// a new division hides the result that just landed
			if (launch)
			begin
				start_q <= 1'b1;
				busy_q  <= 1'b1;
				done_q  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			operands_q <= div_operands_t'(wb_in.dat[OPS_W-1:0]);
		end
	end

	ack_single_cycle: assert property (
		@(posedge clk) disable iff (!rst_n)
		wb_out.ack |=> !wb_out.ack
	) else $error("ack high on two cycles in a row");

	// the master holds its strobe until it has seen ack
	ack_inside_cycle: assert property (
		@(posedge clk) disable iff (!rst_n)
		wb_out.ack |-> (wb_in.cyc && wb_in.stb)
	) else $error("ack without cyc and stb");

endmodule

//--- logic/radix8_long_div.sv
`include "div_macros.svh"

module radix8_long_div
	import div_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          start,
	input  div_operands_t operands,
	output logic          ready,
	output div_result_t   result,
	output logic          result_valid
);

	localparam int DVD_W   = `DIV_DIVIDEND_WIDTH;
	localparam int DVS_W   = `DIV_DIVISOR_WIDTH;
	localparam int DIGIT_W = `DIV_DIGIT_BITS;
	localparam int EXT_W   = `DIV_DIGITS * `DIV_DIGIT_BITS;
	localparam int PART_W  = DVS_W + DIGIT_W;
	localparam int RADIX   = 1 << DIGIT_W;
	localparam int IDX_W   = $clog2(`DIV_DIGITS);

	div_state_e                       state;
	logic [IDX_W-1:0]                 digit_idx;
	// all digits are in, publish on the next edge
	logic                             last_digit;

	logic [EXT_W-1:0]                 dividend_q;
	logic [DVS_W-1:0]                 divisor_q;
	logic                             dbz_q;
	logic [RADIX-1:0][PART_W-1:0]     mult_q;
	logic [DVS_W-1:0]                 rem_q;
	logic [EXT_W-1:0]                 quot_q;

	logic                             accept;
	logic                             divisor_zero;
	logic [DVS_W-1:0]                 divisor_eff;
	logic [PART_W-1:0]                partial;
	logic [DIGIT_W-1:0]               digit;
	logic [PART_W-1:0]                rem_next;

	// largest k with k * divisor <= partial, three compares deep
	function automatic logic [DIGIT_W-1:0] pick_digit(
		input logic [PART_W-1:0]             part,
		input logic [RADIX-1:0][PART_W-1:0] mult
	);
		logic [DIGIT_W-1:0] d;
		d[2] = (mult[4] <= part);
		d[1] = (mult[{d[2], 2'b10}] <= part);
		d[0] = (mult[{d[2:1], 1'b1}] <= part);
		return d;
	endfunction

	assign ready  = (state == DIV_IDLE);
	assign accept = start && ready;

	// divide by zero runs as 0 / 1 so quotient and remainder end up 0
	assign divisor_zero = (operands.divisor == '0);
	assign divisor_eff  = divisor_zero ? DVS_W'(1) : operands.divisor;

	// bring down the next 3 dividend bits
	assign partial  = {rem_q, dividend_q[digit_idx * DIGIT_W +: DIGIT_W]};
	assign digit    = pick_digit(partial, mult_q);
	assign rem_next = partial - mult_q[digit];

	assign result = '{
		quotient:    quot_q[DVD_W-1:0],
		remainder:   rem_q,
		div_by_zero: dbz_q
	};

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state        <= DIV_IDLE;
			digit_idx    <= '0;
			last_digit   <= 1'b0;
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= 1'b0;
			case (state)
				DIV_IDLE:
				begin
					if (accept)
					begin
						state      <= DIV_WORK;
						digit_idx  <= IDX_W'(`DIV_DIGITS - 1);
						last_digit <= 1'b0;
					end
				end
				DIV_WORK:
				begin
					if (last_digit)
					begin
						state        <= DIV_IDLE;
						last_digit   <= 1'b0;
						result_valid <= 1'b1;
					end
					else
					begin
						digit_idx  <= digit_idx - 1'b1;
						last_digit <= (digit_idx == '0);
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			dividend_q <= divisor_zero ? '0 : EXT_W'(operands.dividend);
			divisor_q  <= divisor_eff;
			dbz_q      <= divisor_zero;
			rem_q      <= '0;
			quot_q     <= '0;
			for (int k = 0; k < RADIX; k++)
			begin
				mult_q[k] <= PART_W'(k) * PART_W'(divisor_eff);
			end
		end
		else if (state == DIV_WORK && !last_digit)
		begin
			// digits arrive msb first, shift them in from the right
			quot_q <= {quot_q[EXT_W-DIGIT_W-1:0], digit};
			rem_q  <= rem_next[DVS_W-1:0];
		end
	end

	// the register block must wait for ready before it starts a division
	start_only_when_ready: assert property (
		@(posedge clk) disable iff (!rst_n)
		start |-> ready
	) else $error("start raised while the divider is busy");

	result_valid_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		result_valid |=> !result_valid
	) else $error("result_valid held longer than one cycle");

	remainder_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		(result_valid && !result.div_by_zero) |-> (result.remainder < divisor_q)
	) else $error("remainder not below divisor");

endmodule

//--- run.sh
#!/bin/sh
# compile and run the divide unit testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -f sources.f --top-module tb_div_unit \
	&& ./obj_dir/Vtb_div_unit; } > sim.log 2>&1 \
	|| echo "** FAIL **" >> sim.log
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || exit 1
exit 0

//--- sources.f
+incdir+include
logic/div_pkg.sv
logic/radix8_long_div.sv
logic/div_wb_regs.sv
logic/div_unit_top.sv
tests/div_checker.sv
tests/tb_div_unit.sv

//--- tests/div_checker.sv
`include "div_macros.svh"

module div_checker
	import div_pkg::*;
(
	input logic    clk,
	input logic    rst_n,
	input wb_req_t wb_in,
	input wb_rsp_t wb_out
);

	int unsigned error_count = 0;
	int unsigned ack_count = 0;

	// reference outcome of the last accepted operand write
	div_result_t expected;
	logic        have_expected = 1'b0;
	// first status read after an operand write must show busy
	logic        expect_busy = 1'b0;
	// set by a result read, cleared by the next operand write
	logic        expect_idle = 1'b0;
	logic        ack_prev = 1'b0;

	// plain integer division, a zero divisor gives zeros and the flag
	function automatic div_result_t reference_divide(input div_operands_t ops);
		div_result_t r;
		int unsigned n;
		int unsigned d;
		n = 32'(ops.dividend);
		d = 32'(ops.divisor);
		r = '0;
		r.div_by_zero = (d == 0);
		if (d != 0)
		begin
			r.quotient  = `DIV_DIVIDEND_WIDTH'(n / d);
			r.remainder = `DIV_DIVISOR_WIDTH'(n % d);
		end
		return r;
	endfunction

	task automatic compare_field(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act)
		begin
			error_count++;
			$display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
		end
	endtask

	task automatic report_problem(input string what);
		error_count++;
		$display("at %0t: %s", $time, what);
	endtask

	task automatic check_status(input logic [31:0] rd);
		if (expect_busy && !rd[0])
			report_problem("busy was not set on the first status read after an operand write");
		expect_busy = 1'b0;
		if (rd[0] && rd[1])
			report_problem("busy and done were set together");
		if (expect_idle && rd[1])
			report_problem("done was still set after the result had been read");
		// flag belongs to the captured result, only meaningful once done
		if (rd[1] && have_expected)
			compare_field("status.div_by_zero", 32'(expected.div_by_zero), 32'(rd[2]));
		compare_field("status.unused_bits", 32'h0, 32'(rd[31:3]));
	endtask

	task automatic check_result(input logic [31:0] rd);
		if (!have_expected)
		begin
			report_problem("result register read before any operand write");
			return;
		end
		compare_field("result.quotient", 32'(expected.quotient), 32'(rd[15:0]));
		compare_field("result.remainder", 32'(expected.remainder), 32'(rd[23:16]));
		compare_field("result.unused_bits", 32'h0, 32'(rd[31:24]));
		expect_idle = 1'b1;
	endtask

	task automatic check_transfer();
		if (wb_in.we)
		begin
			if (wb_reg_e'(wb_in.adr) == REG_OPERANDS)
			begin
				expected      = reference_divide(div_operands_t'(wb_in.dat[23:0]));
				have_expected = 1'b1;
				expect_busy   = 1'b1;
				expect_idle   = 1'b0;
			end
		end
		else
		begin
			case (wb_reg_e'(wb_in.adr))
				REG_STATUS: check_status(wb_out.dat);
				REG_RESULT: check_result(wb_out.dat);
				default: compare_field("unmapped_read.dat", 32'h0, wb_out.dat);
			endcase
		end
	endtask

	// an acked cycle is one finished transfer
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			ack_prev = 1'b0;
		end
		else
		begin
			if (wb_out.ack)
			begin
				ack_count++;
				if (!(wb_in.cyc && wb_in.stb))
					report_problem("ack seen without an active bus request");
				else if (ack_prev)
					report_problem("ack held high for two cycles in a row");
				else
					check_transfer();
			end
			ack_prev = wb_out.ack;
		end
	end

endmodule

//--- tests/tb_div_unit.sv
`include "div_macros.svh"

module tb_div_unit
	import div_pkg::*;
();

	logic    clk;
	logic    rst_n;
	wb_req_t wb_in;
	wb_rsp_t wb_out;

	int unsigned ops_issued = 0;
	int unsigned cycles = 0;
	int unsigned tests_run = 0;
	int unsigned tests_failed = 0;
	int unsigned tb_errors = 0;
	int unsigned errors_at_start = 0;
	logic [31:0] lfsr_state = 32'hfbde63fa;

	div_unit_top DUT (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_in  (wb_in),
		.wb_out (wb_out)
	);

	div_checker u_check (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_in  (wb_in),
		.wb_out (wb_out)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#4 clk = ~clk;
		end
	end

	// budget grows with every bus operation issued
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > 40 * ops_issued + 100)
		begin
			$display("timeout: the run stalled at cycle %0d after %0d bus operations",
				cycles, ops_issued);
			$display("** FAIL **");
			$finish;
		end
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic int unsigned total_errors();
		return u_check.error_count + tb_errors;
	endfunction

	// request stays up across the edge that samples ack
	task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
		output logic [31:0] rd);
		ops_issued++;
		@(negedge clk);
		wb_in = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		do
		begin
			@(negedge clk);
		end
		while (!wb_out.ack);
		rd = wb_out.dat;
		@(negedge clk);
		wb_in = '0;
	endtask

	task automatic write_operands(input logic [15:0] dividend, input logic [7:0] divisor);
		logic [31:0] rd;
		bus_access(1'b1, REG_OPERANDS, {8'h0, divisor, dividend}, rd);
	endtask

	task automatic wait_done();
		logic [31:0] st;
		int polls;
		polls = 0;
		do
		begin
			bus_access(1'b0, REG_STATUS, '0, st);
			polls++;
		end
		while (!st[1] && polls < 20);
		if (!st[1])
		begin
			tb_errors++;
			$display("at %0t: done never came up after %0d status polls", $time, polls);
		end
	endtask

	task automatic divide(input logic [15:0] a, input logic [7:0] b);
		logic [31:0] rd;
		write_operands(a, b);
		wait_done();
		bus_access(1'b0, REG_RESULT, '0, rd);
	endtask

	task automatic start_test();
		errors_at_start = total_errors();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (total_errors() != errors_at_start)
		begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end
		else
			$display("test %0d %s: passed", tests_run, name);
	endtask

	initial
	begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] rd;
		int unsigned t0;
		int unsigned acks_before;
		int unsigned ops_before;
		rst_n = 1'b0;
		wb_in = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		start_test();
		divide(16'd65535, 8'd1);
		divide(16'd65535, 8'd255);
		divide(16'd0, 8'd7);
		divide(16'd5, 8'd9);
		divide(16'd1000, 8'd10);
		divide(16'd12345, 8'd8);
		finish_test("directed divisions");

		start_test();
		divide(16'd1234, 8'd0);
		divide(16'd100, 8'd7);
		finish_test("divide by zero");

		start_test();
		for (int i = 0; i < 200; i++)
		begin
			take_bits(16, a);
			take_bits(8, b);
			divide(a[15:0], b[7:0]);
		end
		finish_test("random operands");

		// the result read clears done before this status read
		start_test();
		divide(16'd40000, 8'd123);
		bus_access(1'b0, REG_STATUS, '0, rd);
		finish_test("status sequencing");

		start_test();
		acks_before = u_check.ack_count;
		ops_before = ops_issued;
		write_operands(16'd50000, 8'd3);
		t0 = cycles;
		write_operands(16'd4321, 8'd17);
		if (cycles - t0 < 7)
		begin
			tb_errors++;
			$display("at %0t: second operand write finished without waiting for the core",
				$time);
		end
		wait_done();
		bus_access(1'b0, REG_RESULT, '0, rd);
		if (u_check.ack_count - acks_before != ops_issued - ops_before)
		begin
			tb_errors++;
			$display("at %0t: %0d acks seen for %0d bus operations", $time,
				u_check.ack_count - acks_before, ops_issued - ops_before);
		end
		finish_test("back-pressure");

		start_test();
		write_operands(16'd777, 8'd13);
		wait_done();
		bus_access(1'b0, 4'd7, '0, rd);
		bus_access(1'b1, 4'd5, 32'hffff_ffff, rd);
		// a division started by the stray write would replace the result
		wait_done();
		bus_access(1'b0, REG_RESULT, '0, rd);
		finish_test("unmapped addresses");

		if (u_check.ack_count != ops_issued)
		begin
			tb_errors++;
			$display("%0d acks seen in total for %0d bus operations", u_check.ack_count,
				ops_issued);
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_errors());
		if (tests_failed == 0 && total_errors() == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
